/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_biu_ahb
FILELIST  := biu_ahb.f
OBJDIR    := obj_dir
PASS_MSG  := Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

/* ahb_byte_ram.sv */
// byte-lane RAM
// word wide synchronous memory, per byte write enables, registered read

`timescale 1ns/1ps
`default_nettype none

module ahb_byte_ram #(
  parameter int MEM_WORDS = 256,
  parameter int XLEN      = 32
) (
  input  wire                         HCLK,
  input  wire                         en_i,
  input  wire  [XLEN/8-1:0]           we_i,     // one bit per byte lane
  input  wire  [$clog2(MEM_WORDS)-1:0] addr_i,
  input  wire  [XLEN-1:0]             wdata_i,
  output logic [XLEN-1:0]             rdata_o
);

  logic [XLEN-1:0] mem [MEM_WORDS];

  always_ff @(posedge HCLK) begin
    if (en_i) begin
      // lane writes
      for (int b = 0; b < XLEN / 8; b++) begin
        if (we_i[b]) mem[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
      end
      // read only when no lane is written, rdata holds otherwise
      if (we_i == '0) rdata_o <= mem[addr_i];
    end
  end

endmodule

`default_nettype wire

/* ahb_lite_if.sv */
// AHB-Lite interface
// one master, one slave; hready is the slave's own ready fed back

`timescale 1ns/1ps
`default_nettype none

interface ahb_lite_if #(
  parameter int XLEN = 32,
  parameter int PLEN = 32
);
  import biu_ahb_pkg::*;

  // master driven
  logic            hsel;
  logic [PLEN-1:0] haddr;
  logic            hwrite;
  hsize_t          hsize;
  hburst_t         hburst;
  logic [3:0]      hprot;
  htrans_t         htrans;
  logic            hmastlock;
  logic [XLEN-1:0] hwdata;   // data phase

  // slave driven
  logic [XLEN-1:0] hrdata;
  logic            hready;
  hresp_t          hresp;

  modport master (
    output hsel, haddr, hwrite, hsize, hburst, hprot, htrans, hmastlock, hwdata,
    input  hrdata, hready, hresp
  );

  modport slave (
    input  hsel, haddr, hwrite, hsize, hburst, hprot, htrans, hmastlock, hwdata,
    output hrdata, hready, hresp
  );

endinterface

`default_nettype wire

/* ahb_sram_slave.sv */
// AHB-Lite SRAM slave
// registers the address phase, inserts WAIT_STATES per beat, builds
// byte enables and answers out-of-range addresses with a two cycle ERROR

`timescale 1ns/1ps
`default_nettype none

module ahb_sram_slave #(
  parameter int XLEN        = 32,
  parameter int PLEN        = 32,
  parameter int MEM_WORDS   = 256,
  parameter int WAIT_STATES = 1
) (
  input wire        HCLK,
  input wire        HRESETn,
  ahb_lite_if.slave ahb
);
  import biu_ahb_pkg::*;

  localparam int AW  = $clog2(MEM_WORDS);
  localparam int BW  = XLEN / 8;
  localparam int WCW = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;
  localparam logic [PLEN-1:0] MEM_BYTES = PLEN'(MEM_WORDS * 4);

  logic           req, acc, in_range, rd_req, ready;
  logic           dp_act, dp_wr, dp_err, dp_first, err_2nd;
  logic [WCW-1:0] wait_cnt;
  logic [AW-1:0]  dp_addr;
  logic [BW-1:0]  dp_be, be;
  logic           wr_now, ram_en;
  logic [BW-1:0]  ram_we;
  logic [AW-1:0]  ram_addr;

  assign req      = ahb.hsel && (ahb.htrans == HTRANS_NONSEQ || ahb.htrans == HTRANS_SEQ);
  assign in_range = ahb.haddr < MEM_BYTES;
  assign rd_req   = req && !ahb.hwrite && in_range;  // read issued in its address phase
  assign acc      = req && ready;
  assign wr_now   = dp_act && dp_first && dp_wr && !dp_err;  // hwdata valid from 1st cycle

  // RAM port is shared, a read colliding with a write waits one cycle
  always_comb begin
    if (!dp_act)     ready = 1'b1;
    else if (dp_err) ready = err_2nd;
    else             ready = (wait_cnt == '0) && !(wr_now && rd_req);
  end

  // byte lanes from size and low address bits
  always_comb begin
    case (ahb.hsize)
      HSIZE_BYTE:  be = BW'(1) << ahb.haddr[1:0];
      HSIZE_HWORD: be = BW'(3) << {ahb.haddr[1], 1'b0};
      default:     be = '1;
    endcase
  end

  ////////////////////////////////////////////////////////////////////
  // data phase tracking
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      dp_act   <= 1'b0;
      dp_wr    <= 1'b0;
      dp_err   <= 1'b0;
      dp_first <= 1'b0;
      err_2nd  <= 1'b0;
      wait_cnt <= '0;
    end else if (ready) begin  // current data phase ends, next one opens
      dp_act   <= acc;
      dp_wr    <= acc && ahb.hwrite;
      dp_err   <= acc && !in_range;
      dp_first <= acc;
      err_2nd  <= 1'b0;
      wait_cnt <= WCW'(WAIT_STATES);
    end else begin
      dp_first <= 1'b0;
      if (dp_err) err_2nd <= 1'b1;
      if (wait_cnt != '0) wait_cnt <= wait_cnt - 1'b1;
    end
  end

  always_ff @(posedge HCLK) begin
    if (acc) begin
      dp_addr <= ahb.haddr[AW+1:2];
      dp_be   <= be;
    end
  end

  assign ram_en   = wr_now || (rd_req && ready);
  assign ram_we   = wr_now ? dp_be : '0;
  assign ram_addr = wr_now ? dp_addr : ahb.haddr[AW+1:2];

  assign ahb.hready = ready;
  assign ahb.hresp  = (dp_act && dp_err) ? HRESP_ERROR : HRESP_OKAY;

  ahb_byte_ram #(
    .MEM_WORDS (MEM_WORDS),
    .XLEN      (XLEN)
  ) u_ram (
    .HCLK    (HCLK),
    .en_i    (ram_en),
    .we_i    (ram_we),
    .addr_i  (ram_addr),
    .wdata_i (ahb.hwdata),
    .rdata_o (ahb.hrdata)
  );

  // two cycle ERROR response
  a_err_two_cycle : assert property (
    @(posedge HCLK) disable iff (!HRESETn)
    (ahb.hresp == HRESP_ERROR && !ahb.hready) |=> (ahb.hresp == HRESP_ERROR && ahb.hready)
  ) else $error("ERROR response not completed in its second cycle");

endmodule

`default_nettype wire

/* biu_ahb.f */
biu_ahb_pkg.sv
ahb_lite_if.sv
ahb_byte_ram.sv
ahb_sram_slave.sv
biu_ahb_master.sv
biu_ahb_subsys.sv
tb_clock_gen.sv
tb_biu_ahb.sv

/* biu_ahb_master.sv */
// BIU to AHB-Lite master
// turns the core's strobe bus into NONSEQ/SEQ bursts, counts beats,
// computes incrementing and wrapping addresses and drops a burst on ERROR

`timescale 1ns/1ps
`default_nettype none

module biu_ahb_master #(
  parameter int XLEN = 32,
  parameter int PLEN = 32
) (
  input  wire                          HCLK,
  input  wire                          HRESETn,

  // core side
  input  wire                          biu_stb_i,      // held until stb_ack
  output logic                         biu_stb_ack_o,  // burst accepted
  output logic                         biu_d_ack_o,    // next write beat please
  input  wire  [PLEN-1:0]              biu_adri_i,
  output logic [PLEN-1:0]              biu_adro_o,     // address of acked beat
  input  wire  biu_ahb_pkg::biu_size_t biu_size_i,
  input  wire  biu_ahb_pkg::biu_type_t biu_type_i,
  input  wire  biu_ahb_pkg::biu_prot_t biu_prot_i,
  input  wire                          biu_lock_i,
  input  wire                          biu_we_i,
  input  wire  [XLEN-1:0]              biu_d_i,
  output logic [XLEN-1:0]              biu_q_o,
  output logic                         biu_ack_o,      // beat done with OKAY
  output logic                         biu_err_o,      // burst aborted

  ahb_lite_if.master                   ahb
);
  import biu_ahb_pkg::*;

  logic [3:0] burst_cnt;   // beats still to issue after the current one
  logic       data_ena;    // active transfer in address phase
  logic       data_ena_d;  // active transfer in data phase

  ////////////////////////////////////////////////////////////////////
  // address phase
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      burst_cnt     <= '0;
      data_ena      <= 1'b0;
      biu_err_o     <= 1'b0;
      ahb.hsel      <= 1'b0;
      ahb.haddr     <= '0;
      ahb.hwrite    <= 1'b0;
      ahb.hsize     <= HSIZE_WORD;
      ahb.hburst    <= HBURST_SINGLE;
      ahb.hprot     <= 4'b0011;      // privileged data access
      ahb.htrans    <= HTRANS_IDLE;
      ahb.hmastlock <= 1'b0;
    end else begin
      biu_err_o <= 1'b0;  // single cycle pulse

      if (ahb.hready) begin
        if (burst_cnt == '0) begin
          if (biu_stb_i && !biu_err_o) begin  // new burst
            data_ena      <= 1'b1;
            burst_cnt     <= type2cnt(biu_type_i);
            ahb.hsel      <= 1'b1;
            ahb.htrans    <= HTRANS_NONSEQ;
            ahb.haddr     <= biu_adri_i;
            ahb.hwrite    <= biu_we_i;
            ahb.hsize     <= size2hsize(biu_size_i);
            ahb.hburst    <= type2hburst(biu_type_i);
            ahb.hprot     <= prot2hprot(biu_prot_i);
            ahb.hmastlock <= biu_lock_i;
          end else begin
            data_ena      <= 1'b0;
            ahb.hsel      <= 1'b0;
            ahb.htrans    <= HTRANS_IDLE;
            ahb.hmastlock <= biu_lock_i;  // lock may be held between bursts
          end
        end else begin  // keep the burst going
          data_ena   <= 1'b1;
          burst_cnt  <= burst_cnt - 4'd1;
          ahb.htrans <= HTRANS_SEQ;
          ahb.haddr  <= PLEN'(nxt_addr(64'(ahb.haddr), ahb.hburst));
        end
      end else if (ahb.hresp == HRESP_ERROR) begin
        // first error cycle drops the pending address phase
        burst_cnt  <= '0;
        data_ena   <= 1'b0;
        ahb.hsel   <= 1'b0;
        ahb.htrans <= HTRANS_IDLE;
        biu_err_o  <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////
  // data phase
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      data_ena_d <= 1'b0;
    end else if (ahb.hready) begin
      data_ena_d <= data_ena;
    end
  end

  // payload registers stall with hready
  always_ff @(posedge HCLK) begin
    if (ahb.hready) begin
      biu_adro_o <= ahb.haddr;                 // follows the beat into its data phase
      if (data_ena) ahb.hwdata <= biu_d_i;     // beat data sampled on d_ack
    end
  end

  assign biu_q_o       = ahb.hrdata;
  assign biu_ack_o     = ahb.hready & data_ena_d & (ahb.hresp == HRESP_OKAY);
  assign biu_d_ack_o   = ahb.hready & data_ena;
  assign biu_stb_ack_o = ahb.hready & (burst_cnt == '0) & biu_stb_i & ~biu_err_o;

  ////////////////////////////////////////////////////////////////////
  // protocol checks
  a_no_seq_after_idle : assert property (
    @(posedge HCLK) disable iff (!HRESETn)
    (ahb.htrans == HTRANS_IDLE) |=> (ahb.htrans != HTRANS_SEQ)
  ) else $error("SEQ issued right after IDLE");

  // a multi-beat burst in its first address phase still has beats to issue
  a_no_stb_ack_mid_burst : assert property (
    @(posedge HCLK) disable iff (!HRESETn)
    (ahb.htrans == HTRANS_NONSEQ && ahb.hburst != HBURST_SINGLE &&
     ahb.hburst != HBURST_INCR) |-> !biu_stb_ack_o
  ) else $error("stb_ack while beats of the current burst remain");

endmodule

`default_nettype wire

/* biu_ahb_pkg.sv */
// biu_ahb package
// AHB-Lite code enums, BIU burst/size/protection codes and the
// conversion functions shared by the BIU master and the SRAM slave

`default_nettype none

package biu_ahb_pkg;

  //////////////////////////////////////////////////////////////////////
  // AHB-Lite codes
  typedef enum logic [1:0] {
    HTRANS_IDLE   = 2'b00,
    HTRANS_BUSY   = 2'b01,
    HTRANS_NONSEQ = 2'b10,
    HTRANS_SEQ    = 2'b11
  } htrans_t;

  typedef enum logic [2:0] {
    HSIZE_BYTE  = 3'b000,
    HSIZE_HWORD = 3'b001,
    HSIZE_WORD  = 3'b010
  } hsize_t;

  typedef enum logic [2:0] {
    HBURST_SINGLE = 3'd0,
    HBURST_INCR   = 3'd1,
    HBURST_WRAP4  = 3'd2,
    HBURST_INCR4  = 3'd3,
    HBURST_WRAP8  = 3'd4,
    HBURST_INCR8  = 3'd5,
    HBURST_WRAP16 = 3'd6,
    HBURST_INCR16 = 3'd7
  } hburst_t;

  typedef enum logic {HRESP_OKAY = 1'b0, HRESP_ERROR = 1'b1} hresp_t;

  //////////////////////////////////////////////////////////////////////
  // core side codes
  typedef enum logic [2:0] {
    BIU_SINGLE = 3'd0, BIU_INCR   = 3'd1, BIU_WRAP4  = 3'd2, BIU_INCR4  = 3'd3,
    BIU_WRAP8  = 3'd4, BIU_INCR8  = 3'd5, BIU_WRAP16 = 3'd6, BIU_INCR16 = 3'd7
  } biu_type_t;

  typedef enum logic [2:0] {BIU_BYTE = 3'd0, BIU_HWORD = 3'd1, BIU_WORD = 3'd2} biu_size_t;

  typedef struct packed {
    logic cacheable;   // bit 2
    logic privileged;  // bit 1
    logic data;        // bit 0, 0 = opcode fetch
  } biu_prot_t;

  // beats minus one, INCR is issued as a single beat
  function automatic logic [3:0] type2cnt(input biu_type_t t);
    case (t)
      BIU_WRAP4, BIU_INCR4:   return 4'd3;
      BIU_WRAP8, BIU_INCR8:   return 4'd7;
      BIU_WRAP16, BIU_INCR16: return 4'd15;
      default:                return 4'd0;  // single, incr
    endcase
  endfunction

  // same ordering on both sides
  function automatic hburst_t type2hburst(input biu_type_t t);
    return hburst_t'(t);
  endfunction

  function automatic hsize_t size2hsize(input biu_size_t s);
    case (s)
      BIU_BYTE:  return HSIZE_BYTE;
      BIU_HWORD: return HSIZE_HWORD;
      default:   return HSIZE_WORD;
    endcase
  endfunction

  // {cacheable, bufferable, privileged, data}, never bufferable here
  function automatic logic [3:0] prot2hprot(input biu_prot_t p);
    return {p.cacheable, 1'b0, p.privileged, p.data};
  endfunction

  // next beat address, word steps, wraps keep the bits above the boundary
  function automatic logic [63:0] nxt_addr(input logic [63:0] addr, input hburst_t hburst);
    logic [63:0] lin;
    lin = (addr + 64'd4) & ~64'h3;
    case (hburst)
      HBURST_WRAP4:  return {addr[63:4], lin[3:0]};  // 16 byte window
      HBURST_WRAP8:  return {addr[63:5], lin[4:0]};  // 32 byte window
      HBURST_WRAP16: return {addr[63:6], lin[5:0]};  // 64 byte window
      default:       return lin;
    endcase
  endfunction

endpackage

`default_nettype wire

/* biu_ahb_subsys.sv */
// BIU AHB-Lite subsystem
// core strobe bus in, BIU master and SRAM slave joined by one AHB-Lite link

`timescale 1ns/1ps
`default_nettype none

module biu_ahb_subsys #(
  parameter int XLEN        = 32,
  parameter int PLEN        = 32,
  parameter int MEM_WORDS   = 256,  // SRAM depth, above it ERROR
  parameter int WAIT_STATES = 1     // per data phase
) (
  input  wire                          HCLK,
  input  wire                          HRESETn,

  input  wire                          biu_stb_i,
  output logic                         biu_stb_ack_o,
  output logic                         biu_d_ack_o,
  input  wire  [PLEN-1:0]              biu_adri_i,
  output logic [PLEN-1:0]              biu_adro_o,
  input  wire  biu_ahb_pkg::biu_size_t biu_size_i,
  input  wire  biu_ahb_pkg::biu_type_t biu_type_i,
  input  wire  biu_ahb_pkg::biu_prot_t biu_prot_i,
  input  wire                          biu_lock_i,
  input  wire                          biu_we_i,
  input  wire  [XLEN-1:0]              biu_d_i,
  output logic [XLEN-1:0]              biu_q_o,
  output logic                         biu_ack_o,
  output logic                         biu_err_o
);

  ahb_lite_if #(.XLEN(XLEN), .PLEN(PLEN)) ahb ();

  biu_ahb_master #(.XLEN(XLEN), .PLEN(PLEN)) u_master (
    .HCLK          (HCLK),
    .HRESETn       (HRESETn),
    .biu_stb_i     (biu_stb_i),
    .biu_stb_ack_o (biu_stb_ack_o),
    .biu_d_ack_o   (biu_d_ack_o),
    .biu_adri_i    (biu_adri_i),
    .biu_adro_o    (biu_adro_o),
    .biu_size_i    (biu_size_i),
    .biu_type_i    (biu_type_i),
    .biu_prot_i    (biu_prot_i),
    .biu_lock_i    (biu_lock_i),
    .biu_we_i      (biu_we_i),
    .biu_d_i       (biu_d_i),
    .biu_q_o       (biu_q_o),
    .biu_ack_o     (biu_ack_o),
    .biu_err_o     (biu_err_o),
    .ahb           (ahb.master)
  );

  ahb_sram_slave #(
    .XLEN        (XLEN),
    .PLEN        (PLEN),
    .MEM_WORDS   (MEM_WORDS),
    .WAIT_STATES (WAIT_STATES)
  ) u_slave (
    .HCLK    (HCLK),
    .HRESETn (HRESETn),
    .ahb     (ahb.slave)
  );

endmodule

`default_nettype wire

/* tb_biu_ahb.sv */
// testbench for the BIU AHB-Lite subsystem
// random transfers from an LCG, byte-wide reference memory,
// address sequence and read data checked beat by beat

`timescale 1ns/1ps
`default_nettype none

module tb_biu_ahb;
  import biu_ahb_pkg::*;

  localparam int MEM_WORDS = 256;
  localparam int TMO       = 200;  // cycles per wait

  wire        HCLK;
  wire        HRESETn;

  logic       biu_stb, biu_lock, biu_we;
  logic [31:0] biu_adri, biu_d;
  biu_size_t  biu_size;
  biu_type_t  biu_type;
  biu_prot_t  biu_prot;
  wire        biu_stb_ack, biu_d_ack, biu_ack, biu_err;
  wire [31:0] biu_adro, biu_q;

  logic [7:0]  mem_model [MEM_WORDS*4];  // reference copy of the SRAM
  bit          mem_known [MEM_WORDS*4];  // byte written at least once
  logic [31:0] wbuf [16];                // write data per beat
  logic [31:0] rbuf [16];                // read data per acked beat
  logic [31:0] abuf [16];                // biu_adro per acked beat
  logic [31:0] lcg_state = 32'd19;
  int          errors = 0;
  int          failed_tests = 0;

  biu_type_t incr_types [3] = '{BIU_INCR4, BIU_INCR8, BIU_INCR16};
  biu_type_t wrap_types [3] = '{BIU_WRAP4, BIU_WRAP8, BIU_WRAP16};

  tb_clock_gen #(.PERIOD_NS(4), .RST_CYCLES(8)) u_clk (.clk_o(HCLK), .rst_n_o(HRESETn));

  biu_ahb_subsys #(.XLEN(32), .PLEN(32), .MEM_WORDS(MEM_WORDS), .WAIT_STATES(1)) uut (
    .HCLK (HCLK), .HRESETn (HRESETn),
    .biu_stb_i (biu_stb), .biu_stb_ack_o (biu_stb_ack), .biu_d_ack_o (biu_d_ack),
    .biu_adri_i (biu_adri), .biu_adro_o (biu_adro), .biu_size_i (biu_size),
    .biu_type_i (biu_type), .biu_prot_i (biu_prot), .biu_lock_i (biu_lock),
    .biu_we_i (biu_we), .biu_d_i (biu_d), .biu_q_o (biu_q),
    .biu_ack_o (biu_ack), .biu_err_o (biu_err)
  );

  //////////////////////////////////////////////////////////////////////
  // stimulus and reference helpers
  function automatic logic [31:0] rand32();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return {lcg_state[15:0], lcg_state[31:16]};  // better bits low
  endfunction

  function automatic int beat_count(input biu_type_t t);
    case (t)
      BIU_WRAP4, BIU_INCR4:   return 4;
      BIU_WRAP8, BIU_INCR8:   return 8;
      BIU_WRAP16, BIU_INCR16: return 16;
      default:                return 1;
    endcase
  endfunction

  // expected beat address where wraps stay inside a window of beats*4 bytes
  function automatic logic [31:0] beat_addr(input logic [31:0] start, input biu_type_t t,
                                            input int i);
    logic [31:0] win, lin;
    win = (t == BIU_WRAP4 || t == BIU_WRAP8 || t == BIU_WRAP16) ? 32'(beat_count(t) * 4) : 0;
    lin = (start & ~32'h3) + 32'(4 * i);
    if (i == 0) return start;
    if (win == 0) return lin;
    return (start & ~(win - 1)) | (lin & (win - 1));
  endfunction

  task automatic model_write(input logic [31:0] a, input biu_size_t s, input logic [31:0] d);
    int n, k;
    logic [31:0] base;
    n = (s == BIU_BYTE) ? 1 : (s == BIU_HWORD) ? 2 : 4;
    base = a & ~32'(n - 1);
    for (k = 0; k < n; k++) begin
      mem_model[base + k] = d[8*((base + k) % 4) +: 8];  // byte on its own lane
      mem_known[base + k] = 1'b1;
    end
  endtask

  task automatic check_read(input logic [31:0] a, input logic [31:0] got);
    logic [31:0] w, exp;
    logic ok;
    int k;
    w = a & ~32'h3;
    exp = 'x;
    ok = 1'b1;
    for (k = 0; k < 4; k++) begin
      if (mem_known[w + k]) begin
        exp[8*k +: 8] = mem_model[w + k];
        if (got[8*k +: 8] !== exp[8*k +: 8]) ok = 1'b0;
      end
    end
    assert (ok) else begin
      $display("Fail at %0t ns: read at %h gave %h, model %h", $time, w, got, exp);
      errors++;
    end
  endtask

  task automatic fill_wbuf();
    for (int i = 0; i < 16; i++) wbuf[i] = rand32();
  endtask

  //////////////////////////////////////////////////////////////////////
  // one burst on the strobe bus followed by a model update or a read check
  task automatic xfer(input logic wr, input biu_type_t btype, input biu_size_t bsize,
                      input logic [31:0] addr, input logic expect_err);
    int beats, nd, na, t, i;
    logic seen, got_err, late;
    beats = beat_count(btype);
    nd = 0;
    na = 0;
    got_err = 1'b0;
    late = 1'b0;
    seen = 1'b0;
    @(posedge HCLK);
    biu_stb  <= 1'b1;
    biu_we   <= wr;
    biu_type <= btype;
    biu_size <= bsize;
    biu_adri <= addr;
    biu_d    <= wbuf[0];
    t = 0;
    while (!seen && t < TMO) begin  // strobe held until accepted
      @(negedge HCLK);
      seen = biu_stb_ack;
      t++;
    end
    @(posedge HCLK);
    biu_stb <= 1'b0;
    if (!seen) begin
      $display("Timeout at %0t ns: strobe to %h never acknowledged", $time, addr);
      errors++;
      return;
    end
    t = 0;
    while (na < beats && !got_err && t < TMO) begin
      @(negedge HCLK);
      t++;
      if (biu_ack) begin
        rbuf[na] = biu_q;
        abuf[na] = biu_adro;
        na++;
      end
      got_err = biu_err;
      if (biu_d_ack) begin  // beat data taken on the coming edge
        nd++;
        @(posedge HCLK);
        biu_d <= wbuf[nd % 16];
      end
    end
    if (!got_err && na < beats) begin
      $display("Timeout at %0t ns: %0d of %0d beats acknowledged at %h", $time, na, beats, addr);
      errors++;
      return;
    end
    if (got_err) begin
      repeat (8) begin  // nothing more may come for an aborted burst
        @(negedge HCLK);
        if (biu_ack || biu_err) late = 1'b1;
      end
    end
    assert (got_err == expect_err && !late && (!got_err || na == 0) &&
            (got_err || nd == beats)) else begin
      $display("Fail at %0t ns: burst at %h err %0b expected %0b, acks %0b, data acks %0d, late pulse %0b",
               $time, addr, got_err, expect_err, na, nd, late);
      errors++;
    end
    for (i = 0; i < na; i++) begin
      assert (abuf[i] == beat_addr(addr, btype, i)) else begin
        $display("Fail at %0t ns: beat %0d address %h, expected %h", $time, i, abuf[i],
                 beat_addr(addr, btype, i));
        errors++;
      end
      if (wr) model_write(beat_addr(addr, btype, i), bsize, wbuf[i]);
      else check_read(beat_addr(addr, btype, i), rbuf[i]);
    end
  endtask

  task automatic end_test(input int num, input string name, input int e0);
    if (errors != e0) failed_tests++;
    $display("test %0d %s: %s", num, name, (errors == e0) ? "passed" : "failed");
  endtask

  //////////////////////////////////////////////////////////////////////
  initial begin
    int e0, t, j, w, n, beats;
    logic [31:0] a, r;
    biu_type_t bt;
    biu_size_t bs;
    logic quiet;

    biu_stb  = 1'b0;
    biu_lock = 1'b0;
    biu_we   = 1'b0;
    biu_adri = '0;
    biu_d    = '0;
    biu_size = BIU_WORD;
    biu_type = BIU_SINGLE;
    biu_prot = biu_prot_t'(3'b011);  // data, privileged
    t = 0;
    while (!HRESETn && t < TMO) begin
      @(posedge HCLK);
      t++;
    end
    if (!HRESETn) begin
      $display("Timeout at %0t ns: reset never released", $time);
      errors++;
    end

    // test 1 checks idle outputs and a single word round trip
    e0 = errors;
    quiet = 1'b1;
    repeat (10) begin
      @(negedge HCLK);
      if (biu_ack || biu_d_ack || biu_stb_ack || biu_err) quiet = 1'b0;
    end
    assert (quiet) else begin
      $display("Fail at %0t ns: acknowledge or error without a strobe", $time);
      errors++;
    end
    fill_wbuf();
    xfer(1'b1, BIU_SINGLE, BIU_WORD, 32'h40, 1'b0);
    xfer(1'b0, BIU_SINGLE, BIU_WORD, 32'h40, 1'b0);
    end_test(1, "reset and single word", e0);

    // test 2 writes byte and halfword lanes inside a known word
    e0 = errors;
    repeat (20) begin
      a = (rand32() % 32'(MEM_WORDS)) << 2;
      r = rand32();
      fill_wbuf();
      xfer(1'b1, BIU_SINGLE, BIU_WORD, a, 1'b0);
      bs = r[0] ? BIU_BYTE : BIU_HWORD;
      fill_wbuf();
      xfer(1'b1, BIU_SINGLE, bs, r[0] ? a + r[2:1] : a + {r[1], 1'b0}, 1'b0);
      xfer(1'b0, BIU_SINGLE, BIU_WORD, a, 1'b0);
    end
    end_test(2, "byte and halfword lanes", e0);

    // test 3 incrementing bursts
    e0 = errors;
    for (j = 0; j < 3; j++) begin
      repeat (3) begin
        beats = beat_count(incr_types[j]);
        a = (rand32() % 32'(MEM_WORDS - beats + 1)) << 2;
        fill_wbuf();
        xfer(1'b1, incr_types[j], BIU_WORD, a, 1'b0);
        xfer(1'b0, incr_types[j], BIU_WORD, a, 1'b0);
      end
    end
    end_test(3, "incrementing bursts", e0);

    // test 4 wrapping bursts that never start at the window start
    e0 = errors;
    for (j = 0; j < 3; j++) begin
      repeat (3) begin
        beats = beat_count(wrap_types[j]);
        a = (rand32() % 32'(MEM_WORDS)) << 2;
        if ((a & 32'(beats * 4 - 1)) == 0) a = a + 32'd4;
        fill_wbuf();
        xfer(1'b1, wrap_types[j], BIU_WORD, a, 1'b0);
        xfer(1'b0, wrap_types[j], BIU_WORD, a, 1'b0);
      end
    end
    end_test(4, "wrapping bursts", e0);

    // test 5 out of range burst where the alias words below keep their data
    e0 = errors;
    a = 32'h400 + (rand32() & 32'h3c0);
    fill_wbuf();
    xfer(1'b1, BIU_INCR4, BIU_WORD, a & 32'h3ff, 1'b0);
    fill_wbuf();
    xfer(1'b1, BIU_INCR4, BIU_WORD, a, 1'b1);
    xfer(1'b0, BIU_INCR4, BIU_WORD, a & 32'h3ff, 1'b0);
    fill_wbuf();
    xfer(1'b1, BIU_SINGLE, BIU_WORD, 32'h80, 1'b0);
    xfer(1'b0, BIU_SINGLE, BIU_WORD, 32'h80, 1'b0);
    end_test(5, "error response", e0);

    // test 6 random mix followed by a read back of every touched word
    e0 = errors;
    for (n = 0; n < 200; n++) begin
      r = rand32();
      bt = biu_type_t'(r[2:0]);
      beats = beat_count(bt);
      bs = (beats == 1) ? biu_size_t'(r[4:3] % 2'd3) : BIU_WORD;  // bursts are word wide
      a = (rand32() % 32'(MEM_WORDS - beats + 1)) << 2;
      if (bs == BIU_BYTE) a = a + r[6:5];
      else if (bs == BIU_HWORD) a = a + {r[6], 1'b0};
      fill_wbuf();
      xfer(r[7], bt, bs, a, 1'b0);
    end
    for (w = 0; w < MEM_WORDS; w++) begin
      if (mem_known[4*w] || mem_known[4*w+1] || mem_known[4*w+2] || mem_known[4*w+3])
        xfer(1'b0, BIU_SINGLE, BIU_WORD, 32'(4 * w), 1'b0);
    end
    end_test(6, "random mix", e0);

    $display("tests run: 6, failed tests: %0d, failed checks: %0d", failed_tests, errors);
    if (errors == 0) $display("Simulation finished: PASS");
    else $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
// testbench clock and reset
// free running HCLK, HRESETn held low for a number of cycles

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS  = 4,
  parameter int RST_CYCLES = 8
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;                    // in reset from time zero
    repeat (RST_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;                   // released on a rising edge
  end

endmodule

`default_nettype wire
